// ==== hw/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_DATA_W      32
`define CPU_PC_W        11  // word address, instructions and data
`define CPU_REG_CNT     16
`define CPU_QUEUE_DEPTH 4

// instruction word layout
`define CPU_OP_MSB   31
`define CPU_OP_LSB   28
`define CPU_COND_MSB 27
`define CPU_COND_LSB 24
`define CPU_RD_MSB   23
`define CPU_RD_LSB   20
`define CPU_RN_MSB   19
`define CPU_RN_LSB   16
`define CPU_RM_MSB   15
`define CPU_RM_LSB   12
`define CPU_IMM_MSB  11
`define CPU_IMM_LSB  0

`endif

// ==== hw/isa_pkg.sv ====
`include "cpu_params.svh"

package isa_pkg;

    typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_idx_t;
    typedef logic [`CPU_IMM_MSB-`CPU_IMM_LSB:0] imm12_t;

    // top nibble of the instruction word
    // any encoding not listed runs as a no-op
    typedef enum logic [`CPU_OP_MSB-`CPU_OP_LSB:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_ORR  = 4'h3,
        OP_MOV  = 4'h4,  // rd = imm12
        OP_LDR  = 4'h5,  // rd = mem[rn + imm12]
        OP_STR  = 4'h6,  // mem[rn + imm12] = rd
        OP_B    = 4'h7,  // absolute target in imm12
        OP_HALT = 4'hf
    } opcode_e;

    typedef enum logic [`CPU_COND_MSB-`CPU_COND_LSB:0] {
        CC_EQ = 4'h0,
        CC_NE = 4'h1,
        CC_AL = 4'he
    } cond_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_ORR = 2'd3
    } alu_op_e;

endpackage : isa_pkg

// ==== hw/core_pkg.sv ====
`include "cpu_params.svh"

package core_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t;
    typedef logic [`CPU_PC_W-1:0]   addr_t;

    // execute side of the core
    typedef enum logic [1:0] {
        S_WAIT, // waiting on the instruction queue
        S_EXEC,
        S_MEM,  // data bus cycle open until ack
        S_HALT
    } ctrl_state_e;

endpackage : core_pkg

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t start_pc,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  queue_space,
    output logic  reserve,      // a live fetch is in flight
    output logic  ibus_cyc,
    output logic  ibus_stb,
    output addr_t ibus_adr,
    input  word_t ibus_dat_rd,
    input  logic  ibus_ack,
    output logic  push,
    output word_t push_data
);

    typedef enum logic {F_IDLE, F_BUSY} fetch_state_e;

    fetch_state_e state_q;
    addr_t        fetch_pc;
    logic         stale_q;      // outstanding cycle belongs to an old stream
    logic         start;

    // no new request in a redirect cycle, the pc is about to change
    assign start = (state_q == F_IDLE) && queue_space && !redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= F_IDLE;
            fetch_pc <= start_pc;
            ibus_adr <= start_pc;
            stale_q  <= 1'b0;
        end else begin
            if (start) begin
                state_q  <= F_BUSY;
                ibus_adr <= fetch_pc;   // held until ack
                fetch_pc <= fetch_pc + 1'b1;
            end else if (state_q == F_BUSY && ibus_ack) begin
                state_q <= F_IDLE;      // bus drops for at least one cycle
            end

            if (redirect)
                fetch_pc <= redirect_pc;

            if (state_q == F_BUSY && ibus_ack)
                stale_q <= 1'b0;
            else if (state_q == F_BUSY && redirect)
                stale_q <= 1'b1;
        end
    end

    assign ibus_cyc  = (state_q == F_BUSY);
    assign ibus_stb  = (state_q == F_BUSY);
    assign reserve   = (state_q == F_BUSY) && !stale_q;
    // word from a flushed stream never reaches the queue
    assign push      = (state_q == F_BUSY) && ibus_ack && !stale_q && !redirect;
    assign push_data = ibus_dat_rd;

    // the slave acks only a live request
    a_ack_in_cycle : assert property (@(posedge clk) disable iff (rst)
        ibus_ack |-> ibus_cyc && ibus_stb)
        else $error("ibus ack outside a bus cycle");

    a_adr_stable : assert property (@(posedge clk) disable iff (rst)
        ibus_stb && !ibus_ack |=> $stable(ibus_adr))
        else $error("ibus address changed before ack");

endmodule : fetch_unit

// ==== hw/instr_queue.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module instr_queue import core_pkg::*; #(
    parameter int DEPTH = `CPU_QUEUE_DEPTH
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  flush,
    input  logic  push,
    input  word_t push_data,
    input  logic  reserve,      // fetch has a word on the way
    output logic  space,
    input  logic  pop,
    output logic  valid,
    output word_t head
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    // in-flight word counts as taken
    assign space = reserve ? (count < CNT_W'(DEPTH - 1)) : (count < CNT_W'(DEPTH));
    assign valid = (count != '0);
    assign head  = mem[rd_ptr];

    a_no_overrun : assert property (@(posedge clk) disable iff (rst)
        push |-> count < CNT_W'(DEPTH))
        else $error("push into full instruction queue");

    a_no_underrun : assert property (@(posedge clk) disable iff (rst)
        pop |-> count != '0)
        else $error("pop from empty instruction queue");

endmodule : instr_queue

// ==== hw/controller.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module controller import core_pkg::*; import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  addr_t    start_pc,
    input  logic     q_valid,
    input  word_t    q_data,
    output logic     pop,
    input  word_t    status,
    output logic     redirect,
    output addr_t    redirect_pc,
    output addr_t    pc,
    output reg_idx_t rd,
    output reg_idx_t rn,
    output reg_idx_t rm,
    output imm12_t   imm12,
    output alu_op_e  alu_op,
    output logic     sel_imm,
    output logic     reg_w_en,
    output logic     sel_load,
    output logic     flag_en,
    output logic     dbus_cyc,
    output logic     dbus_stb,
    output logic     dbus_we,
    input  logic     dbus_ack,
    output logic     halted
);

    ctrl_state_e state_q, state_d;
    addr_t       seq_pc;    // address of the next word out of the queue
    opcode_e     op_q;
    cond_e       cond_q;
    reg_idx_t    rd_q, rn_q, rm_q;
    imm12_t      imm12_q;
    logic        cond_pass;

    // fields stay put for the whole instruction
    always_ff @(posedge clk) begin
        if (pop) begin
            op_q    <= opcode_e'(q_data[`CPU_OP_MSB:`CPU_OP_LSB]);
            cond_q  <= cond_e'(q_data[`CPU_COND_MSB:`CPU_COND_LSB]);
            rd_q    <= q_data[`CPU_RD_MSB:`CPU_RD_LSB];
            rn_q    <= q_data[`CPU_RN_MSB:`CPU_RN_LSB];
            rm_q    <= q_data[`CPU_RM_MSB:`CPU_RM_LSB];
            imm12_q <= q_data[`CPU_IMM_MSB:`CPU_IMM_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_WAIT;
            seq_pc  <= start_pc;
            pc      <= start_pc;
        end else begin
            state_q <= state_d;
            if (pop) begin
                pc     <= seq_pc;
                seq_pc <= seq_pc + 1'b1;
            end else if (redirect) begin
                seq_pc <= redirect_pc;
            end
        end
    end

    // Z is status bit 30
    always_comb begin
        case (cond_q)
            CC_EQ:   cond_pass = status[`CPU_DATA_W-2];
            CC_NE:   cond_pass = !status[`CPU_DATA_W-2];
            CC_AL:   cond_pass = 1'b1;
            default: cond_pass = 1'b0;
        endcase
    end

    always_comb begin
        state_d  = state_q;
        pop      = 1'b0;
        redirect = 1'b0;
        alu_op   = ALU_ADD;
        sel_imm  = 1'b0;
        reg_w_en = 1'b0;
        sel_load = 1'b0;
        flag_en  = 1'b0;
        dbus_cyc = 1'b0;
        dbus_stb = 1'b0;
        dbus_we  = 1'b0;
        case (state_q)
            S_WAIT: begin
                if (q_valid) begin
                    pop     = 1'b1;
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                state_d = S_WAIT;
                case (op_q)
                    OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_MOV: begin
                        reg_w_en = 1'b1;
                        flag_en  = 1'b1;
                        sel_imm  = (op_q == OP_MOV);
                        alu_op   = (op_q == OP_SUB) ? ALU_SUB :
                                   (op_q == OP_AND) ? ALU_AND :
                                   (op_q == OP_ADD) ? ALU_ADD : ALU_ORR;
                    end
                    OP_LDR, OP_STR: state_d = S_MEM;
                    OP_B:           redirect = cond_pass;
                    OP_HALT:        state_d = S_HALT;
                    default:        state_d = S_WAIT;  // no-op
                endcase
            end
            S_MEM: begin
                dbus_cyc = 1'b1;
                dbus_stb = 1'b1;
                dbus_we  = (op_q == OP_STR);
                if (dbus_ack) begin
                    reg_w_en = (op_q == OP_LDR);    // load data lands on ack
                    sel_load = 1'b1;
                    state_d  = S_WAIT;
                end
            end
            default: state_d = S_HALT;  // S_HALT, left only by reset
        endcase
    end

    // MOV reads r15 as operand A, which the datapath treats as zero
    assign rn          = (op_q == OP_MOV) ? reg_idx_t'(`CPU_REG_CNT - 1) : rn_q;
    assign rd          = rd_q;
    assign rm          = rm_q;
    assign imm12       = imm12_q;
    assign redirect_pc = imm12_q[`CPU_PC_W-1:0];
    assign halted      = (state_q == S_HALT);

    a_halt_sticky : assert property (@(posedge clk) disable iff (rst)
        state_q == S_HALT |=> state_q == S_HALT)
        else $error("controller left halt without reset");

endmodule : controller

// ==== hw/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath import core_pkg::*; import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd,
    input  reg_idx_t rn,
    input  reg_idx_t rm,
    input  imm12_t   imm12,
    input  alu_op_e  alu_op,
    input  logic     sel_imm,
    input  logic     reg_w_en,
    input  logic     sel_load,
    input  logic     flag_en,
    input  word_t    dbus_dat_rd,
    output addr_t    dbus_adr,
    output word_t    dbus_dat_wr,
    output word_t    status,
    input  reg_idx_t reg_addr,
    output word_t    reg_output
);

    localparam int MSB = `CPU_DATA_W - 1;

    word_t                regs [`CPU_REG_CNT];
    word_t                op_a, op_b, alu_y, wb_data, mem_sum;
    logic [`CPU_DATA_W:0] add_full, sub_full;   // carry out in the top bit
    logic [3:0]           nzcv_q;
    logic                 c_nxt, v_nxt;

    // r15 is a zero source on operand A only, writes to it still land
    assign op_a = (rn == reg_idx_t'(`CPU_REG_CNT - 1)) ? '0 : regs[rn];
    assign op_b = sel_imm ? word_t'(imm12) : regs[rm];

    assign add_full = {1'b0, op_a} + {1'b0, op_b};
    assign sub_full = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;

    always_comb begin
        c_nxt = nzcv_q[1];  // logic ops keep C and V
        v_nxt = nzcv_q[0];
        case (alu_op)
            ALU_ADD: begin
                alu_y = add_full[MSB:0];
                c_nxt = add_full[`CPU_DATA_W];
                v_nxt = (op_a[MSB] == op_b[MSB]) && (alu_y[MSB] != op_a[MSB]);
            end
            ALU_SUB: begin
                alu_y = sub_full[MSB:0];
                c_nxt = sub_full[`CPU_DATA_W];     // set when no borrow
                v_nxt = (op_a[MSB] != op_b[MSB]) && (alu_y[MSB] != op_a[MSB]);
            end
            ALU_AND: alu_y = op_a & op_b;
            default: alu_y = op_a | op_b;
        endcase
    end

    assign wb_data = sel_load ? dbus_dat_rd : alu_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_CNT; i++)
                regs[i] <= '0;
        end else if (reg_w_en) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            nzcv_q <= '0;
        else if (flag_en)
            nzcv_q <= {alu_y[MSB], (alu_y == '0), c_nxt, v_nxt};
    end

    // own adder so the bus address does not depend on alu_op
    assign mem_sum     = op_a + word_t'(imm12);
    assign dbus_adr    = mem_sum[`CPU_PC_W-1:0];
    assign dbus_dat_wr = regs[rd];

    assign status     = {nzcv_q, {(`CPU_DATA_W - 4){1'b0}}};
    assign reg_output = regs[reg_addr];  // debug read

endmodule : datapath

// ==== hw/cpu.sv ====
`timescale 1ns/1ps

module cpu import core_pkg::*; import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  addr_t    start_pc,
    output logic     ibus_cyc,
    output logic     ibus_stb,
    output addr_t    ibus_adr,
    input  word_t    ibus_dat_rd,
    input  logic     ibus_ack,
    output logic     dbus_cyc,
    output logic     dbus_stb,
    output logic     dbus_we,
    output addr_t    dbus_adr,
    output word_t    dbus_dat_wr,
    input  word_t    dbus_dat_rd,
    input  logic     dbus_ack,
    output addr_t    pc,
    output word_t    status,
    output logic     halted,
    input  reg_idx_t reg_addr,
    output word_t    reg_output
);

    // fetch to queue
    logic  push, reserve, space;
    word_t push_data;
    // queue to controller
    logic  q_valid, pop;
    word_t q_data;
    logic  redirect;
    addr_t redirect_pc;
    // controller to datapath
    reg_idx_t rd, rn, rm;
    imm12_t   imm12;
    alu_op_e  alu_op;
    logic     sel_imm, reg_w_en, sel_load, flag_en;

    fetch_unit fetch_unit (
        .clk(clk), .rst(rst), .start_pc(start_pc),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .queue_space(space), .reserve(reserve),
        .ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
        .ibus_dat_rd(ibus_dat_rd), .ibus_ack(ibus_ack),
        .push(push), .push_data(push_data)
    );

    instr_queue instr_queue (
        .clk(clk), .rst(rst), .flush(redirect),
        .push(push), .push_data(push_data), .reserve(reserve), .space(space),
        .pop(pop), .valid(q_valid), .head(q_data)
    );

    controller controller (
        .clk(clk), .rst(rst), .start_pc(start_pc),
        .q_valid(q_valid), .q_data(q_data), .pop(pop), .status(status),
        .redirect(redirect), .redirect_pc(redirect_pc), .pc(pc),
        .rd(rd), .rn(rn), .rm(rm), .imm12(imm12), .alu_op(alu_op),
        .sel_imm(sel_imm), .reg_w_en(reg_w_en), .sel_load(sel_load), .flag_en(flag_en),
        .dbus_cyc(dbus_cyc), .dbus_stb(dbus_stb), .dbus_we(dbus_we),
        .dbus_ack(dbus_ack), .halted(halted)
    );

    datapath datapath (
        .clk(clk), .rst(rst),
        .rd(rd), .rn(rn), .rm(rm), .imm12(imm12), .alu_op(alu_op),
        .sel_imm(sel_imm), .reg_w_en(reg_w_en), .sel_load(sel_load), .flag_en(flag_en),
        .dbus_dat_rd(dbus_dat_rd), .dbus_adr(dbus_adr), .dbus_dat_wr(dbus_dat_wr),
        .status(status), .reg_addr(reg_addr), .reg_output(reg_output)
    );

endmodule : cpu

// ==== verification/wb_mem_model.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module wb_mem_model import core_pkg::*; #(
    parameter int         DEPTH = 1 << `CPU_PC_W,
    parameter logic [7:0] SEED  = 8'd58
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  ibus_cyc,
    input  logic  ibus_stb,
    input  addr_t ibus_adr,
    output word_t ibus_dat_rd,
    output logic  ibus_ack,
    input  logic  dbus_cyc,
    input  logic  dbus_stb,
    input  logic  dbus_we,
    input  addr_t dbus_adr,
    input  word_t dbus_dat_wr,
    output word_t dbus_dat_rd,
    output logic  dbus_ack
);

    word_t      mem [DEPTH];
    logic [7:0] lfsr_q;
    logic [1:0] i_wait, d_wait;     // wait states left before ack
    logic       i_busy, d_busy;

    // galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    task automatic write_word(input addr_t adr, input word_t data);
        mem[adr] = data;
    endtask

    initial begin
        for (int a = 0; a < DEPTH; a++)
            mem[a] = 32'hd000_0000 | a;  // opcode d, executes as a no-op
        ibus_ack    = 1'b0;
        dbus_ack    = 1'b0;
        ibus_dat_rd = '0;
        dbus_dat_rd = '0;
        i_busy      = 1'b0;
        d_busy      = 1'b0;
        lfsr_q      = SEED;
    end

    always @(posedge clk) begin : serve
        logic [7:0] lf;
        logic [1:0] w;
        lf = lfsr_q;
        if (rst) begin
            lfsr_q   <= SEED;
            i_busy   <= 1'b0;
            d_busy   <= 1'b0;
            ibus_ack <= #1 1'b0;
            dbus_ack <= #1 1'b0;
        end else begin
            // instruction port, read only
            if (i_busy) begin
                if (i_wait == 2'd0) begin
                    ibus_ack    <= #1 1'b1;
                    ibus_dat_rd <= #1 mem[ibus_adr];
                    i_busy      <= 1'b0;
                end else begin
                    ibus_ack <= #1 1'b0;
                    i_wait   <= i_wait - 1'b1;
                end
            end else begin
                ibus_ack <= #1 1'b0;
                if (ibus_cyc && ibus_stb && !ibus_ack) begin   // new request
                    w[0] = lf[0];
                    lf   = lfsr_next(lf);
                    w[1] = lf[0];
                    lf   = lfsr_next(lf);
                    i_wait <= w;
                    i_busy <= 1'b1;
                end
            end
            // data port
            if (d_busy) begin
                if (d_wait == 2'd0) begin
                    dbus_ack <= #1 1'b1;
                    if (dbus_we)
                        mem[dbus_adr] <= dbus_dat_wr;
                    else
                        dbus_dat_rd <= #1 mem[dbus_adr];
                    d_busy <= 1'b0;
                end else begin
                    dbus_ack <= #1 1'b0;
                    d_wait   <= d_wait - 1'b1;
                end
            end else begin
                dbus_ack <= #1 1'b0;
                if (dbus_cyc && dbus_stb && !dbus_ack) begin
                    w[0] = lf[0];
                    lf   = lfsr_next(lf);
                    w[1] = lf[0];
                    lf   = lfsr_next(lf);
                    d_wait <= w;
                    d_busy <= 1'b1;
                end
            end
            lfsr_q <= lf;
        end
    end

endmodule : wb_mem_model

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import core_pkg::*; import isa_pkg::*; ();

    localparam addr_t START_PC       = 11'd16;
    localparam int    PROG_LEN       = 24;
    localparam int    TIMEOUT_CYCLES = 40 * PROG_LEN * 5;
    localparam word_t OPND_A         = 32'h5a;
    localparam word_t OPND_B         = 32'h3c;
    localparam word_t BASE           = 32'h200;  // data area, clear of the program
    localparam addr_t SUB_N_PC       = START_PC + 11'd10;
    localparam addr_t SUB_Z_PC       = START_PC + 11'd11;
    localparam addr_t MARK_PC        = START_PC + 11'd14;  // two markers, never executed
    localparam addr_t JOIN_PC        = START_PC + 11'd16;
    localparam addr_t LOOP_PC        = START_PC + 11'd18;

    logic     clk, rst;
    addr_t    start_pc;
    logic     ibus_cyc, ibus_stb, ibus_ack;
    addr_t    ibus_adr;
    word_t    ibus_dat_rd;
    logic     dbus_cyc, dbus_stb, dbus_we, dbus_ack;
    addr_t    dbus_adr;
    word_t    dbus_dat_wr, dbus_dat_rd;
    addr_t    pc;
    word_t    status;
    logic     halted;
    reg_idx_t reg_addr;
    word_t    reg_output;
    logic [5:0] bus_ctl;

    word_t exp_reg [16];
    addr_t exp_st_adr [3];
    word_t exp_st_dat [3];
    int    cycle_cnt = 0;
    int    store_cnt = 0;
    logic  rst_q = 1'b1;
    logic  first_fetch_seen = 1'b0;

    cpu dut_i (.*);

    wb_mem_model #(.SEED(8'd58)) mem_i (.*);

    assign bus_ctl = {ibus_cyc, ibus_stb, dbus_cyc, dbus_stb, dbus_we, halted};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    // op 31:28, cond 27:24, rd 23:20, rn 19:16, rm 15:12, imm 11:0
    function automatic word_t encode(input opcode_e op, input cond_e cond,
                                     input int rd, input int rn, input int rm, input int imm);
        return {op, cond, reg_idx_t'(rd), reg_idx_t'(rn), reg_idx_t'(rm), imm12_t'(imm)};
    endfunction

    task automatic build_expected();
        exp_reg[1]  = BASE;
        exp_reg[2]  = OPND_A;
        exp_reg[3]  = OPND_B;
        exp_reg[4]  = OPND_A + OPND_B;
        exp_reg[5]  = OPND_A - OPND_B;
        exp_reg[6]  = OPND_A & OPND_B;
        exp_reg[7]  = OPND_A | OPND_B;
        exp_reg[8]  = exp_reg[7];       // loaded back from BASE+5
        exp_reg[9]  = OPND_B - OPND_A;  // negative result
        exp_reg[10] = '0;
        exp_reg[11] = '0;               // markers behind the taken BEQ
        exp_reg[12] = '0;
        exp_reg[13] = 32'd3;            // loop counter
        exp_reg[14] = 32'd1;
        exp_reg[15] = '0;               // last compare, 3 - 3
        exp_reg[0]  = exp_reg[4];       // loaded back from BASE
        exp_st_adr[0] = addr_t'(BASE);
        exp_st_dat[0] = exp_reg[4];
        exp_st_adr[1] = addr_t'(BASE + 5);
        exp_st_dat[1] = exp_reg[7];
        exp_st_adr[2] = addr_t'(BASE + 1);
        exp_st_dat[2] = exp_reg[13];
    endtask

    task automatic load_program();
        word_t prog [$];
        prog.push_back(encode(OP_MOV, CC_AL, 1, 0, 0, BASE));
        prog.push_back(encode(OP_MOV, CC_AL, 2, 0, 0, OPND_A));
        prog.push_back(encode(OP_MOV, CC_AL, 3, 0, 0, OPND_B));
        prog.push_back(encode(OP_ADD, CC_AL, 4, 2, 3, 0));
        prog.push_back(encode(OP_SUB, CC_AL, 5, 2, 3, 0));
        prog.push_back(encode(OP_AND, CC_AL, 6, 2, 3, 0));
        prog.push_back(encode(OP_ORR, CC_AL, 7, 2, 3, 0));
        prog.push_back(encode(OP_STR, CC_AL, 4, 1, 0, 0));
        prog.push_back(encode(OP_STR, CC_AL, 7, 1, 0, 5));
        prog.push_back(encode(OP_LDR, CC_AL, 8, 1, 0, 5));
        prog.push_back(encode(OP_SUB, CC_AL, 9, 3, 2, 0));   // sets N
        prog.push_back(encode(OP_SUB, CC_AL, 10, 2, 2, 0));  // sets Z
        prog.push_back(encode(OP_B, CC_NE, 0, 0, 0, MARK_PC));
        prog.push_back(encode(OP_B, CC_EQ, 0, 0, 0, JOIN_PC));
        prog.push_back(encode(OP_MOV, CC_AL, 11, 0, 0, 12'hbad));
        prog.push_back(encode(OP_MOV, CC_AL, 12, 0, 0, 12'hbad));
        prog.push_back(encode(OP_MOV, CC_AL, 0, 0, 0, 3));
        prog.push_back(encode(OP_MOV, CC_AL, 14, 0, 0, 1));
        prog.push_back(encode(OP_ADD, CC_AL, 13, 13, 14, 0)); // loop head
        prog.push_back(encode(OP_SUB, CC_AL, 15, 13, 0, 0));
        prog.push_back(encode(OP_B, CC_NE, 0, 0, 0, LOOP_PC));
        prog.push_back(encode(OP_STR, CC_AL, 13, 1, 0, 1));
        prog.push_back(encode(OP_LDR, CC_AL, 0, 1, 0, 0));
        prog.push_back(encode(OP_HALT, CC_AL, 0, 0, 0, 0));
        if (prog.size() != PROG_LEN)
            fail_run("program length does not match PROG_LEN");
        for (int i = 0; i < prog.size(); i++)
            mem_i.write_word(START_PC + addr_t'(i), prog[i]);
    endtask

    always @(posedge clk) begin : monitor
        cycle_cnt <= cycle_cnt + 1;
        rst_q     <= rst;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            fail_run($sformatf("timeout, no halt within %0d cycles", TIMEOUT_CYCLES));
        if (!rst && ibus_stb && !first_fetch_seen) begin
            first_fetch_seen <= 1'b1;
            assert (ibus_adr == START_PC)
                else report_mismatch("ibus_adr", word_t'(START_PC), word_t'(ibus_adr));
        end
        if (!rst && dbus_cyc && dbus_stb && dbus_we && dbus_ack) begin
            if (store_cnt >= 3) begin
                fail_run("more stores on the data bus than the program holds");
            end else begin
                assert (dbus_adr == exp_st_adr[store_cnt])
                    else report_mismatch("dbus_adr", word_t'(exp_st_adr[store_cnt]),
                                         word_t'(dbus_adr));
                assert (dbus_dat_wr == exp_st_dat[store_cnt])
                    else report_mismatch("dbus_dat_wr", exp_st_dat[store_cnt], dbus_dat_wr);
                store_cnt <= store_cnt + 1;
            end
        end
    end

    a_reset_quiet : assert property (@(posedge clk)
        (rst || rst_q) && cycle_cnt >= 1 |-> bus_ctl == '0)
        else report_mismatch("{ibus_cyc,ibus_stb,dbus_cyc,dbus_stb,dbus_we,halted}",
                             '0, word_t'($sampled(bus_ctl)));

    a_ibus_stb_cyc : assert property (@(posedge clk) disable iff (rst) ibus_stb |-> ibus_cyc)
        else fail_run("ibus stb raised without cyc");

    a_dbus_stb_cyc : assert property (@(posedge clk) disable iff (rst) dbus_stb |-> dbus_cyc)
        else fail_run("dbus stb raised without cyc");

    a_ibus_hold : assert property (@(posedge clk) disable iff (rst)
        ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr))
        else fail_run("ibus request dropped or address changed before ack");

    a_dbus_hold : assert property (@(posedge clk) disable iff (rst)
        dbus_stb && !dbus_ack |=> dbus_stb && $stable(dbus_we) && $stable(dbus_adr)
                                  && $stable(dbus_dat_wr))
        else fail_run("dbus request changed before ack");

    // status read back once pc moves past the instruction
    a_sub_neg : assert property (@(posedge clk) disable iff (rst)
        $past(pc) == SUB_N_PC && pc != SUB_N_PC |-> status[31])
        else report_mismatch("status[31]", 32'd1, word_t'($sampled(status[31])));

    a_sub_zero : assert property (@(posedge clk) disable iff (rst)
        $past(pc) == SUB_Z_PC && pc != SUB_Z_PC |-> status[30])
        else report_mismatch("status[30]", 32'd1, word_t'($sampled(status[30])));

    a_no_skipped_pc : assert property (@(posedge clk) disable iff (rst)
        pc != MARK_PC && pc != MARK_PC + 1'b1)
        else fail_run($sformatf("pc showed skipped address %h", $sampled(pc)));

    initial begin
        rst      = 1'b1;
        start_pc = START_PC;
        reg_addr = '0;
        build_expected();
        @(posedge clk);
        #1;
        load_program();
        repeat (15) @(posedge clk);
        #1 rst = 1'b0;
        while (!halted)
            @(posedge clk);
        for (int r = 0; r < 16; r++) begin
            #1 reg_addr = reg_idx_t'(r);
            @(posedge clk);
            assert (reg_output == exp_reg[r])
                else report_mismatch($sformatf("reg_output r%0d", r), exp_reg[r], reg_output);
        end
        // last flag write is 3 - 3, Z and C (no borrow)
        assert (status == 32'h6000_0000)
            else report_mismatch("status", 32'h6000_0000, status);
        for (int i = 0; i < 3; i++) begin
            assert (mem_i.mem[exp_st_adr[i]] == exp_st_dat[i])
                else report_mismatch($sformatf("mem[%h]", exp_st_adr[i]), exp_st_dat[i],
                                     mem_i.mem[exp_st_adr[i]]);
        end
        if (store_cnt != 3) begin
            fail_run($sformatf("expected 3 stores on the data bus, saw %0d", store_cnt));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule : cpu_tb

// ==== src.f ====
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/fetch_unit.sv
hw/instr_queue.sv
hw/controller.sv
hw/datapath.sv
hw/cpu.sv
verification/wb_mem_model.sv
verification/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/core_pkg.sv
      - hw/fetch_unit.sv
      - hw/instr_queue.sv
      - hw/controller.sv
      - hw/datapath.sv
      - hw/cpu.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/wb_mem_model.sv
      - verification/cpu_tb.sv
